// ==== dbg_frame_pkg.sv ====
//////////////////////////////////////////////////////////////////////
// Debug unit frame layout as it is shifted in from the TAP
// Select flag, payload union, opcodes, module IDs and the strobes
// that the top level hands to each debug module
//////////////////////////////////////////////////////////////////////

`default_nettype none

package dbg_frame_pkg;

  // Input frame and response widths, both shifted LSB first
  localparam int unsigned FRAME_W = 53;
  localparam int unsigned RESP_W  = 33;

  // Module commands
  typedef enum logic [3:0] {
    OP_NOP      = 4'd0,
    OP_BUS_WR   = 4'd1,
    OP_BUS_RD   = 4'd2,
    OP_CPU_CTRL = 4'd3
  } dbg_op_e;

  // IDs 2 and 3 are left empty
  typedef enum logic [1:0] {
    MOD_BUS = 2'd0,
    MOD_CPU = 2'd1
  } dbg_mod_id_e;

  // Payload seen as a module select
  typedef struct packed {
    dbg_mod_id_e id;
    logic [49:0] pad;
  } dbg_sel_t;

  // Payload seen as a module command
  typedef struct packed {
    dbg_op_e     op;
    logic [15:0] addr;
    logic [31:0] data;
  } dbg_cmd_t;

  // Same 52 bits, decoding picked by the select flag
  typedef union packed {
    dbg_sel_t sel;
    dbg_cmd_t cmd;
  } dbg_payload_u;

  typedef struct packed {
    logic         sel_flag;
    dbg_payload_u payload;
  } dbg_frame_t;

  // Per-module DR strobes, already gated by selection
  typedef struct packed {
    logic cmd;
    logic capture;
    logic shift;
  } dbg_strobe_t;

endpackage

`default_nettype wire

// ==== dbg_bus_pkg.sv ====
//////////////////////////////////////////////////////////////////////
// Memory-side bus of the debug unit
// Request and response words of the four-phase req/ack port
//////////////////////////////////////////////////////////////////////

`default_nettype none

package dbg_bus_pkg;

  localparam int unsigned BUS_AW = 16;
  localparam int unsigned BUS_DW = 32;

  // Held stable by the master while req is high
  typedef struct packed {
    logic              we;
    logic [BUS_AW-1:0] addr;
    logic [BUS_DW-1:0] wdata;
  } bus_req_t;

  // Valid while ack is high
  typedef struct packed {
    logic [BUS_DW-1:0] rdata;
  } bus_rsp_t;

endpackage

`default_nettype wire

// ==== dbg_req_ack_master.sv ====
//////////////////////////////////////////////////////////////////////
// Four-phase req/ack master for single bus transfers
// Gives up after RESP_TIMEOUT cycles without ack and flags an error
//////////////////////////////////////////////////////////////////////

`timescale 1ns/100ps
`default_nettype none

module dbg_req_ack_master #(
  parameter int unsigned RESP_TIMEOUT = 64
) (
  input  wire                              tck_i,
  input  wire                              rst_i,
  input  wire                              start_i,
  input  dbg_bus_pkg::bus_req_t            req_i,
  input  wire                              bus_ack_i,
  input  dbg_bus_pkg::bus_rsp_t            bus_rsp_i,
  output dbg_bus_pkg::bus_req_t            bus_req_o,
  output logic                             bus_req_valid_o,
  output logic                             busy_o,
  output logic                             done_o,
  output logic                             err_o,
  output logic [dbg_bus_pkg::BUS_DW-1:0]   rdata_o
);

  localparam int unsigned CNT_W = $clog2(RESP_TIMEOUT + 1);

  // Done comes right after req drops, release waits for ack low
  typedef enum logic [1:0] {
    ST_IDLE,
    ST_REQ,
    ST_DONE,
    ST_REL
  } state_e;

  state_e           state_q;
  logic [CNT_W-1:0] cnt_q;
  logic             err_q;

  always_ff @(posedge tck_i or posedge rst_i) begin
    if (rst_i) begin
      state_q <= ST_IDLE;
      cnt_q   <= '0;
      err_q   <= 1'b0;
    end else begin
      case (state_q)
        ST_IDLE: begin
          if (start_i) begin
            state_q <= ST_REQ;
            cnt_q   <= '0;
            err_q   <= 1'b0;
          end
        end
        ST_REQ: begin
          if (bus_ack_i) begin
            state_q <= ST_DONE;
          end else if (cnt_q == CNT_W'(RESP_TIMEOUT - 1)) begin
            // No ack in time, memory will not answer late
            state_q <= ST_DONE;
            err_q   <= 1'b1;
          end else begin
            cnt_q <= cnt_q + 1'b1;
          end
        end
        ST_DONE: state_q <= bus_ack_i ? ST_REL : ST_IDLE;
        ST_REL: begin
          if (!bus_ack_i) begin
            state_q <= ST_IDLE;
          end
        end
        default: state_q <= ST_IDLE;
      endcase
    end
  end

  // Request word and read data
  always_ff @(posedge tck_i) begin
    if (state_q == ST_IDLE && start_i) begin
      bus_req_o <= req_i;
    end
    if (state_q == ST_REQ && bus_ack_i) begin
      rdata_o <= bus_rsp_i.rdata;
    end
  end

  assign bus_req_valid_o = (state_q == ST_REQ);
  assign busy_o          = (state_q != ST_IDLE);
  assign done_o          = (state_q == ST_DONE);
  assign err_o           = (state_q == ST_DONE) & err_q;

endmodule

`default_nettype wire

// ==== dbg_bus_module.sv ====
//////////////////////////////////////////////////////////////////////
// Bus debug module (ID 0)
// Turns bus opcodes into single req/ack transfers and keeps the last
// read data with the error bit for the 33-bit response
//////////////////////////////////////////////////////////////////////

`timescale 1ns/100ps
`default_nettype none

module dbg_bus_module #(
  parameter int unsigned RESP_TIMEOUT = 64
) (
  input  wire                        tck_i,
  input  wire                        rst_i,
  input  dbg_frame_pkg::dbg_strobe_t strobe_i,
  input  dbg_frame_pkg::dbg_cmd_t    cmd_i,
  input  wire                        bus_ack_i,
  input  dbg_bus_pkg::bus_rsp_t      bus_rsp_i,
  output logic                       tdo_o,
  output logic                       inhibit_o,
  output dbg_bus_pkg::bus_req_t      bus_req_o,
  output logic                       bus_req_valid_o
);

  import dbg_frame_pkg::*;
  import dbg_bus_pkg::*;

  logic              is_bus_op;
  logic              start;
  bus_req_t          req_n;
  logic              busy;
  logic              done;
  logic              xfer_err;
  logic [BUS_DW-1:0] rdata;

  logic [BUS_DW-1:0] data_q;
  logic [BUS_DW-1:0] data_n;
  logic              err_q;
  logic              err_n;
  logic [RESP_W-1:0] resp_q;

  //////////////////////////////////////////////////////////////////////
  // Command decode
  //////////////////////////////////////////////////////////////////////

  assign is_bus_op = (cmd_i.op == OP_BUS_WR) | (cmd_i.op == OP_BUS_RD);
  // Commands that arrive mid-transfer are dropped
  assign start = strobe_i.cmd & is_bus_op & ~busy;

  assign req_n = '{we: (cmd_i.op == OP_BUS_WR), addr: cmd_i.addr, wdata: cmd_i.data};

  dbg_req_ack_master #(
    .RESP_TIMEOUT (RESP_TIMEOUT)
  ) dbg_req_ack_master_i (
    .tck_i           (tck_i),
    .rst_i           (rst_i),
    .start_i         (start),
    .req_i           (req_n),
    .bus_ack_i       (bus_ack_i),
    .bus_rsp_i       (bus_rsp_i),
    .bus_req_o       (bus_req_o),
    .bus_req_valid_o (bus_req_valid_o),
    .busy_o          (busy),
    .done_o          (done),
    .err_o           (xfer_err),
    .rdata_o         (rdata)
  );

  // Whole transfer, ack release included, holds off reselection
  assign inhibit_o = busy;

  //////////////////////////////////////////////////////////////////////
  // Result of the last transfer
  //////////////////////////////////////////////////////////////////////

  // Next-state view also feeds capture, so a capture in the done
  // cycle already sees the new result
  always_comb begin
    data_n = data_q;
    err_n  = err_q;
    if (done) begin
      err_n = xfer_err;
      // Writes and timeouts keep the old read data
      if (!xfer_err && !bus_req_o.we) begin
        data_n = rdata;
      end
    end
  end

  always_ff @(posedge tck_i or posedge rst_i) begin
    if (rst_i) begin
      data_q <= '0;
      err_q  <= 1'b0;
    end else begin
      data_q <= data_n;
      err_q  <= err_n;
    end
  end

  //////////////////////////////////////////////////////////////////////
  // Response shifter
  //////////////////////////////////////////////////////////////////////

  // Error on top, read data below, zeros fill from the top
  always_ff @(posedge tck_i or posedge rst_i) begin
    if (rst_i) begin
      resp_q <= '0;
    end else if (strobe_i.capture) begin
      resp_q <= {err_n, data_n};
    end else if (strobe_i.shift) begin
      resp_q <= {1'b0, resp_q[RESP_W-1:1]};
    end
  end

  assign tdo_o = resp_q[0];

endmodule

`default_nettype wire

// ==== dbg_cpu_module.sv ====
//////////////////////////////////////////////////////////////////////
// CPU debug module (ID 1)
// Stall and reset controls, sticky breakpoint flag and the 33-bit
// status response
//////////////////////////////////////////////////////////////////////

`timescale 1ns/100ps
`default_nettype none

module dbg_cpu_module (
  input  wire                        tck_i,
  input  wire                        rst_i,
  input  dbg_frame_pkg::dbg_strobe_t strobe_i,
  input  dbg_frame_pkg::dbg_cmd_t    cmd_i,
  input  wire                        cpu_bp_i,
  output logic                       tdo_o,
  output logic                       inhibit_o,
  output logic                       cpu_stall_o,
  output logic                       cpu_rst_o
);

  import dbg_frame_pkg::*;

  logic              ctrl_wr;
  logic              stall_q;
  logic              rst_q;
  logic              bp_q;
  logic [RESP_W-1:0] resp_q;

  //////////////////////////////////////////////////////////////////////
  // Control register
  //////////////////////////////////////////////////////////////////////

  assign ctrl_wr = strobe_i.cmd & (cmd_i.op == OP_CPU_CTRL);

  always_ff @(posedge tck_i or posedge rst_i) begin
    if (rst_i) begin
      stall_q <= 1'b0;
      rst_q   <= 1'b0;
      bp_q    <= 1'b0;
    end else begin
      if (ctrl_wr) begin
        stall_q <= cmd_i.data[0];
        rst_q   <= cmd_i.data[1];
        // Writing the control word acknowledges the breakpoint
        bp_q    <= 1'b0;
      end
      // Breakpoint wins over a write in the same cycle
      if (cpu_bp_i) begin
        stall_q <= 1'b1;
        bp_q    <= 1'b1;
      end
    end
  end

  assign cpu_stall_o = stall_q;
  assign cpu_rst_o   = rst_q;

  // Updates are single cycle, never busy
  assign inhibit_o = 1'b0;

  //////////////////////////////////////////////////////////////////////
  // Response shifter
  //////////////////////////////////////////////////////////////////////

  // Stall in bit 0, reset in bit 1, breakpoint in bit 2
  always_ff @(posedge tck_i or posedge rst_i) begin
    if (rst_i) begin
      resp_q <= '0;
    end else if (strobe_i.capture) begin
      resp_q <= {{(RESP_W-3){1'b0}}, bp_q, rst_q, stall_q};
    end else if (strobe_i.shift) begin
      resp_q <= {1'b0, resp_q[RESP_W-1:1]};
    end
  end

  assign tdo_o = resp_q[0];

endmodule

`default_nettype wire

// ==== dbg_top.sv ====
//////////////////////////////////////////////////////////////////////
// Top level of the JTAG debug unit
// Collects the 53-bit frame, latches the module selection, gates the
// DR strobes per module and muxes TDO back to the TAP
//////////////////////////////////////////////////////////////////////

`timescale 1ns/100ps
`default_nettype none

module dbg_top #(
  // Cycles to wait for a bus ack
  parameter int unsigned RESP_TIMEOUT = 64
) (
  input  wire                    tck_i,
  input  wire                    rst_i,
  // TAP side
  input  wire                    tdi_i,
  input  wire                    shift_dr_i,
  input  wire                    capture_dr_i,
  input  wire                    update_dr_i,
  input  wire                    debug_select_i,
  output logic                   tdo_o,
  // Memory side
  output dbg_bus_pkg::bus_req_t  bus_req_o,
  output logic                   bus_req_valid_o,
  input  wire                    bus_ack_i,
  input  dbg_bus_pkg::bus_rsp_t  bus_rsp_i,
  // CPU side
  input  wire                    cpu_bp_i,
  output logic                   cpu_stall_o,
  output logic                   cpu_rst_o
);

  import dbg_frame_pkg::*;

  dbg_frame_t  frame_q;
  dbg_mod_id_e mod_sel_q;

  logic        dr_cmd;
  logic        dr_cap;
  logic        dr_shift;
  logic        sel_upd;
  logic        bus_hit;
  logic        cpu_hit;
  dbg_strobe_t bus_stb;
  dbg_strobe_t cpu_stb;
  logic        bus_tdo;
  logic        cpu_tdo;
  logic        bus_inhibit;
  logic        cpu_inhibit;
  logic        select_inhibit;

  //////////////////////////////////////////////////////////////////////
  // Frame shift register and module selection
  //////////////////////////////////////////////////////////////////////

  assign dr_shift = debug_select_i & shift_dr_i;
  assign dr_cap   = debug_select_i & capture_dr_i;
  // Update with flag clear is a module command
  assign dr_cmd   = debug_select_i & update_dr_i & ~frame_q.sel_flag;

  // Busy module freezes the selection
  assign select_inhibit = bus_inhibit | cpu_inhibit;
  assign sel_upd = debug_select_i & update_dr_i & frame_q.sel_flag & ~select_inhibit;

  // tdi enters at the top, frame is complete after 53 shifts
  always_ff @(posedge tck_i or posedge rst_i) begin
    if (rst_i) begin
      frame_q <= '0;
    end else if (dr_shift) begin
      frame_q <= {tdi_i, frame_q[FRAME_W-1:1]};
    end
  end

  always_ff @(posedge tck_i or posedge rst_i) begin
    if (rst_i) begin
      mod_sel_q <= MOD_BUS;
    end else if (sel_upd) begin
      mod_sel_q <= frame_q.payload.sel.id;
    end
  end

  //////////////////////////////////////////////////////////////////////
  // Strobe gating
  //////////////////////////////////////////////////////////////////////

  assign bus_hit = (mod_sel_q == MOD_BUS);
  assign cpu_hit = (mod_sel_q == MOD_CPU);

  assign bus_stb = '{cmd: dr_cmd & bus_hit, capture: dr_cap & bus_hit, shift: dr_shift & bus_hit};
  assign cpu_stb = '{cmd: dr_cmd & cpu_hit, capture: dr_cap & cpu_hit, shift: dr_shift & cpu_hit};

  dbg_bus_module #(
    .RESP_TIMEOUT (RESP_TIMEOUT)
  ) dbg_bus_module_i (
    .tck_i           (tck_i),
    .rst_i           (rst_i),
    .strobe_i        (bus_stb),
    .cmd_i           (frame_q.payload.cmd),
    .bus_ack_i       (bus_ack_i),
    .bus_rsp_i       (bus_rsp_i),
    .tdo_o           (bus_tdo),
    .inhibit_o       (bus_inhibit),
    .bus_req_o       (bus_req_o),
    .bus_req_valid_o (bus_req_valid_o)
  );

  dbg_cpu_module dbg_cpu_module_i (
    .tck_i       (tck_i),
    .rst_i       (rst_i),
    .strobe_i    (cpu_stb),
    .cmd_i       (frame_q.payload.cmd),
    .cpu_bp_i    (cpu_bp_i),
    .tdo_o       (cpu_tdo),
    .inhibit_o   (cpu_inhibit),
    .cpu_stall_o (cpu_stall_o),
    .cpu_rst_o   (cpu_rst_o)
  );

  // TDO mux, empty IDs read as zero
  always_comb begin
    case (mod_sel_q)
      MOD_BUS: tdo_o = bus_tdo;
      MOD_CPU: tdo_o = cpu_tdo;
      default: tdo_o = 1'b0;
    endcase
  end

endmodule

`default_nettype wire

// ==== tb_dbg_top.sv ====
//////////////////////////////////////////////////////////////////////
// Testbench for the JTAG debug unit
// Plays the TAP side, models memory and CPU, runs random bus
// traffic, timeout, inhibit, CPU control and empty-ID tests
//////////////////////////////////////////////////////////////////////

`timescale 1ns/100ps
`default_nettype none

module tb_dbg_top;

  import dbg_frame_pkg::*;
  import dbg_bus_pkg::*;

  localparam int unsigned RESP_TIMEOUT = 80;

  logic tck_i, rst_i, tdi_i, shift_dr_i, capture_dr_i, update_dr_i;
  logic debug_select_i, tdo_o, bus_req_valid_o, bus_ack_i;
  logic cpu_bp_i, cpu_stall_o, cpu_rst_o;
  bus_req_t bus_req_o;
  bus_rsp_t bus_rsp_i;

  // Memory model state
  logic [31:0] mem [logic [15:0]];
  logic [31:0] exp_mem [logic [15:0]];
  logic        hold_ack, req_seen;
  int          ack_delay, ack_wait;

  // Expected DUT state
  logic [31:0] last_data;
  logic        last_err, cpu_stall, cpu_rst, cpu_bp;
  logic [RESP_W-1:0] resp;
  logic [31:0] rnd;
  logic [31:0] wr_data;
  integer      seed;

  dbg_top #(
    .RESP_TIMEOUT (RESP_TIMEOUT)
  ) dbg_top_i (
    .tck_i (tck_i), .rst_i (rst_i), .tdi_i (tdi_i), .shift_dr_i (shift_dr_i),
    .capture_dr_i (capture_dr_i), .update_dr_i (update_dr_i),
    .debug_select_i (debug_select_i), .tdo_o (tdo_o), .bus_req_o (bus_req_o),
    .bus_req_valid_o (bus_req_valid_o), .bus_ack_i (bus_ack_i), .bus_rsp_i (bus_rsp_i),
    .cpu_bp_i (cpu_bp_i), .cpu_stall_o (cpu_stall_o), .cpu_rst_o (cpu_rst_o)
  );

  always #2 tck_i = ~tck_i;

  // Unwritten words, pattern covers every address bit
  function automatic logic [31:0] fill_word(input logic [15:0] addr);
    return {addr ^ 16'hA5C3, ~addr};
  endfunction

  function automatic logic [31:0] exp_word(input logic [15:0] addr);
    return exp_mem.exists(addr) ? exp_mem[addr] : fill_word(addr);
  endfunction

  //////////////////////////////////////////////////////////////////////
  // Memory model, four-phase slave, silent from FF00 up
  //////////////////////////////////////////////////////////////////////

  always @(posedge tck_i) begin
    #1;
    if (!bus_req_valid_o) begin
      req_seen  = 1'b0;
      bus_ack_i = 1'b0;
    end else if (!req_seen) begin
      req_seen = 1'b1;
      ack_wait = ack_delay;
    end
    if (bus_req_valid_o && !bus_ack_i && !hold_ack && bus_req_o.addr < 16'hFF00) begin
      if (ack_wait == 0) begin
        if (bus_req_o.we) begin
          mem[bus_req_o.addr] = bus_req_o.wdata;
        end else begin
          bus_rsp_i.rdata = mem.exists(bus_req_o.addr) ? mem[bus_req_o.addr]
                                                       : fill_word(bus_req_o.addr);
        end
        bus_ack_i = 1'b1;
      end else begin
        ack_wait = ack_wait - 1;
      end
    end
  end

  //////////////////////////////////////////////////////////////////////
  // Error reporting and compare tasks
  //////////////////////////////////////////////////////////////////////

  task automatic fail_stop(input string msg);
    $display("%s", msg);
    $display("Verification failed");
    $fatal(1, "stopping at first error");
  endtask

  task automatic check_resp(input string name, input logic [RESP_W-1:0] exp,
                            input logic [RESP_W-1:0] act);
    if (act !== exp) fail_stop($sformatf("[FAIL] %s: expected %h, actual %h", name, exp, act));
  endtask

  task automatic check_req(input string name, input bus_req_t exp, input bus_req_t act);
    if (act !== exp) fail_stop($sformatf("[FAIL] %s: expected %h, actual %h", name, exp, act));
  endtask

  // Reset in bit 1, stall in bit 0
  task automatic check_cpu(input string name, input logic [1:0] exp, input logic [1:0] act);
    if (act !== exp) fail_stop($sformatf("[FAIL] %s: expected %b, actual %b", name, exp, act));
  endtask

  task automatic check_bit(input string name, input logic exp, input logic act);
    if (act !== exp) fail_stop($sformatf("[FAIL] %s: expected %b, actual %b", name, exp, act));
  endtask

  //////////////////////////////////////////////////////////////////////
  // TAP frame tasks, inputs change 1 ns after the rising edge
  //////////////////////////////////////////////////////////////////////

  task automatic tick();
    @(posedge tck_i);
    #1;
  endtask

  // LSB first
  task automatic shift_frame(input dbg_frame_t f);
    for (int i = 0; i < FRAME_W; i++) begin
      tdi_i      = f[i];
      shift_dr_i = 1'b1;
      tick();
    end
    shift_dr_i = 1'b0;
    tdi_i      = 1'b0;
  endtask

  task automatic do_update();
    update_dr_i = 1'b1;
    tick();
    update_dr_i = 1'b0;
  endtask

  // Capture, then sample tdo ahead of each shift edge
  task automatic read_resp(output logic [RESP_W-1:0] r);
    capture_dr_i = 1'b1;
    tick();
    capture_dr_i = 1'b0;
    for (int i = 0; i < RESP_W; i++) begin
      r[i]       = tdo_o;
      shift_dr_i = 1'b1;
      tick();
    end
    shift_dr_i = 1'b0;
  endtask

  task automatic select_module(input logic [1:0] id);
    dbg_frame_t f;
    f = '0;
    f.sel_flag = 1'b1;
    f.payload.sel.id = dbg_mod_id_e'(id);
    shift_frame(f);
    do_update();
  endtask

  task automatic send_cmd(input dbg_op_e op, input logic [15:0] addr, input logic [31:0] data);
    dbg_frame_t f;
    f = '0;
    f.payload.cmd.op   = op;
    f.payload.cmd.addr = addr;
    f.payload.cmd.data = data;
    shift_frame(f);
    do_update();
  endtask

  task automatic wait_req(input logic level, input int limit, input string name);
    int n;
    n = 0;
    while (bus_req_valid_o !== level && n < limit) begin
      tick();
      n++;
    end
    if (bus_req_valid_o !== level) begin
      fail_stop($sformatf("%s: bus request did not go to %b within %0d cycles",
                          name, level, limit));
    end
  endtask

  // One transfer, request word checked as it rises
  task automatic bus_xfer(input string name, input logic we, input logic [15:0] addr,
                          input logic [31:0] data);
    bus_req_t exp_req;
    exp_req = '{we: we, addr: addr, wdata: data};
    send_cmd(we ? OP_BUS_WR : OP_BUS_RD, addr, data);
    wait_req(1'b1, 4, name);
    check_req(name, exp_req, bus_req_o);
    wait_req(1'b0, RESP_TIMEOUT + 2, name);
  endtask

  task automatic cpu_write(input string name, input logic [31:0] data);
    send_cmd(OP_CPU_CTRL, 16'h0000, data);
    cpu_stall = data[0];
    cpu_rst   = data[1];
    cpu_bp    = 1'b0;
    check_cpu(name, {cpu_rst, cpu_stall}, {cpu_rst_o, cpu_stall_o});
    read_resp(resp);
    check_resp(name, {30'b0, cpu_bp, cpu_rst, cpu_stall}, resp);
  endtask

  //////////////////////////////////////////////////////////////////////
  // Test sequence
  //////////////////////////////////////////////////////////////////////

  initial begin
    seed = 32'h2a2e_24a8;
    tck_i = 1'b0;
    rst_i = 1'b1;
    tdi_i = 1'b0;
    shift_dr_i = 1'b0;
    capture_dr_i = 1'b0;
    update_dr_i = 1'b0;
    debug_select_i = 1'b1;
    bus_ack_i = 1'b0;
    bus_rsp_i = '0;
    cpu_bp_i = 1'b0;
    hold_ack = 1'b0;
    req_seen = 1'b0;
    ack_delay = 0;
    ack_wait = 0;
    last_data = '0;
    last_err = 1'b0;
    wr_data = '0;
    cpu_stall = 1'b0;
    cpu_rst = 1'b0;
    cpu_bp = 1'b0;
    repeat (3) @(posedge tck_i);
    #1;
    rst_i = 1'b0;

    // After reset
    check_bit("reset req valid", 1'b0, bus_req_valid_o);
    check_cpu("reset cpu", 2'b00, {cpu_rst_o, cpu_stall_o});
    check_bit("reset tdo", 1'b0, tdo_o);

    // Random bus traffic in a small window so reads hit writes
    for (int i = 0; i < 40; i++) begin
      rnd       = $random(seed);
      ack_delay = $unsigned($random(seed)) % 9;
      wr_data   = $random(seed);
      bus_xfer($sformatf("bus_xfer %0d", i), rnd[8], {11'h008, rnd[4:0]}, wr_data);
      if (rnd[8]) begin
        exp_mem[{11'h008, rnd[4:0]}] = wr_data;
      end else begin
        last_data = exp_word({11'h008, rnd[4:0]});
      end
      last_err = 1'b0;
      read_resp(resp);
      check_resp($sformatf("bus_resp %0d", i), {last_err, last_data}, resp);
    end

    // Timeout keeps the old read data
    rnd = $random(seed);
    bus_xfer("timeout", 1'b0, {8'hFF, rnd[7:0]}, 32'h0);
    last_err = 1'b1;
    read_resp(resp);
    check_resp("timeout resp", {last_err, last_data}, resp);

    // Select while the bus module is busy is dropped
    hold_ack  = 1'b1;
    ack_delay = 0;
    send_cmd(OP_BUS_RD, 16'h0040, 32'h0);
    wait_req(1'b1, 4, "inhibit");
    select_module(2'd1);
    hold_ack = 1'b0;
    wait_req(1'b0, RESP_TIMEOUT + 2, "inhibit");
    last_data = exp_word(16'h0040);
    last_err  = 1'b0;
    read_resp(resp);
    check_resp("inhibit bus resp", {last_err, last_data}, resp);
    select_module(2'd1);
    read_resp(resp);
    check_resp("inhibit cpu select", {30'b0, cpu_bp, cpu_rst, cpu_stall}, resp);

    // CPU control, breakpoint, then a write that clears the flag
    cpu_write("cpu write", $random(seed));
    cpu_bp_i = 1'b1;
    tick();
    cpu_bp_i  = 1'b0;
    cpu_stall = 1'b1;
    cpu_bp    = 1'b1;
    check_cpu("cpu breakpoint", {cpu_rst, cpu_stall}, {cpu_rst_o, cpu_stall_o});
    read_resp(resp);
    check_resp("cpu bp resp", {30'b0, cpu_bp, cpu_rst, cpu_stall}, resp);
    cpu_write("cpu clear bp", $random(seed));

    // Nonzero CPU status ahead of the empty IDs
    cpu_write("cpu set", 32'h0000_0003);

    // Empty IDs
    select_module(2'd2);
    read_resp(resp);
    check_resp("id 2 resp", '0, resp);
    select_module(2'd3);
    read_resp(resp);
    check_resp("id 3 resp", '0, resp);

    $display("Verification passed");
    $finish;
  end

endmodule

`default_nettype wire

// ==== vlog.f ====
dbg_frame_pkg.sv
dbg_bus_pkg.sv
dbg_req_ack_master.sv
dbg_bus_module.sv
dbg_cpu_module.sv
dbg_top.sv
tb_dbg_top.sv

// ==== run.sh ====
#!/bin/sh
# Build and run the debug unit testbench with Verilator
set -e
cd "$(dirname "$0")"

verilator --binary --timing -f vlog.f --top-module tb_dbg_top -o sim_tb
./obj_dir/sim_tb 2>&1 | tee sim.log

if grep -q "Verification passed" sim.log; then
  echo "Simulation PASSED"
else
  echo "Simulation FAILED"
  exit 1
fi
